// ==== rtl/mem_cfg_pkg.sv ====
`default_nettype none

package mem_cfg_pkg;

    // Client ports and memory geometry
    localparam int num_rt = 4;
    localparam int num_region = 4;
    localparam int num_bank = 4;
    localparam int row_w = 6;
    localparam int addr_w = 10;

    // Read strobe to data in cycles
    localparam int rd_latency = 5;

    // Pipeline stage where the banks are accessed
    localparam int ram_stage = 2;

    // Burst line count of 1 to 16 lines
    localparam int burst_len_w = 5;

endpackage

`default_nettype wire

// ==== rtl/mem_types_pkg.sv ====
`default_nettype none

package mem_types_pkg;

    typedef logic [31:0] word_t;

    // Word 0 sits in the low bits
    typedef word_t [mem_cfg_pkg::num_bank-1:0] line_t;

    typedef logic [mem_cfg_pkg::addr_w-1:0] waddr_t;
    typedef logic [mem_cfg_pkg::row_w-1:0] row_t;

    // Bank index that doubles as the line rotation amount
    typedef logic [$clog2(mem_cfg_pkg::num_bank)-1:0] bank_sel_t;
    typedef logic [$clog2(mem_cfg_pkg::num_region)-1:0] region_t;

endpackage

`default_nettype wire

// ==== rtl/delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module delay_line
    import mem_cfg_pkg::*;
#(
    parameter type payload_t = logic,
    parameter int depth = rd_latency
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  payload_t  d,
    output payload_t  q
);

    payload_t pipe [depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= d;
            for (int i = 1; i < depth; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign q = pipe[depth-1];

endmodule

`default_nettype wire

// ==== rtl/bank_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_ram
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  wire logic clk,
    input  wire logic we,
    input  row_t      addr,
    input  word_t     wdata,
    output word_t     rdata
);

    word_t mem [2**row_w];

    // Read-first so a write returns the old word
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_main.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_main
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic we [num_rt],
    input  wire logic re [num_rt],
    input  waddr_t    addr [num_rt],
    input  line_t     wdata [num_rt],
    output logic      rd_rdy [num_rt],
    output line_t     rdata [num_rt]
);

    bank_sel_t split_start [num_rt];
    row_t      split_row [num_rt];
    region_t   split_region [num_rt];

    logic [$clog2(num_rt)-1:0] own_port [num_region];
    logic                      own_we [num_region];

    row_t  s0_row [num_rt][num_bank];
    word_t s0_wdata [num_rt][num_bank];
    logic [$clog2(num_rt)-1:0] s0_owner [num_region];
    logic  s0_region_we [num_region];

    row_t  bank_row [num_region][num_bank];
    word_t bank_wdata [num_region][num_bank];
    logic  bank_we [num_region];
    word_t ram_q [num_region][num_bank];

    region_t   rgn_d [num_rt];
    bank_sel_t rot_d [num_rt];
    logic      vld_d [num_rt];
    line_t     s3_line [num_rt];
    line_t     s4_line [num_rt];

    genvar p, r, b;

    // Address split and per-bank row and data
    for (p = 0; p < num_rt; p++) begin : g_split
        assign split_start[p] = bank_sel_t'(addr[p]);
        assign split_row[p] = row_t'(addr[p] >> $bits(bank_sel_t));
        assign split_region[p] = region_t'(addr[p] >> (addr_w - $bits(region_t)));

        for (b = 0; b < num_bank; b++) begin : g_bank
            // Words that wrap past bank 3 land one row up
            always_ff @(posedge clk) begin
                s0_row[p][b] <= split_row[p] + row_t'(bank_sel_t'(b) < split_start[p]);
                s0_wdata[p][b] <= wdata[p][bank_sel_t'(b - split_start[p])];
            end
        end

        delay_line #(.payload_t(logic), .depth(rd_latency - 1)) u_vld_pipe (
            .clk(clk), .rst_n(rst_n), .d(re[p]), .q(vld_d[p])
        );
        delay_line #(.payload_t(region_t), .depth(ram_stage + 1)) u_rgn_pipe (
            .clk(clk), .rst_n(rst_n), .d(split_region[p]), .q(rgn_d[p])
        );
        delay_line #(.payload_t(bank_sel_t), .depth(rd_latency)) u_rot_pipe (
            .clk(clk), .rst_n(rst_n), .d(split_start[p]), .q(rot_d[p])
        );
    end

    // Lowest active port wins each region
    always_comb begin
        for (int i = 0; i < num_region; i++) begin
            own_port[i] = '0;
            own_we[i] = 1'b0;
            for (int j = num_rt - 1; j >= 0; j--) begin
                if ((we[j] || re[j]) && split_region[j] == region_t'(i)) begin
                    own_port[i] = ($clog2(num_rt))'(j);
                    own_we[i] = we[j];
                end
            end
        end
    end

    for (r = 0; r < num_region; r++) begin : g_region
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                s0_region_we[r] <= 1'b0;
                bank_we[r] <= 1'b0;
            end else begin
                s0_region_we[r] <= own_we[r];
                bank_we[r] <= s0_region_we[r];
            end
        end

        always_ff @(posedge clk) begin
            s0_owner[r] <= own_port[r];
        end

        for (b = 0; b < num_bank; b++) begin : g_bank
            always_ff @(posedge clk) begin
                bank_row[r][b] <= s0_row[s0_owner[r]][b];
                bank_wdata[r][b] <= s0_wdata[s0_owner[r]][b];
            end

            bank_ram u_bank (
                .clk(clk),
                .we(bank_we[r]),
                .addr(bank_row[r][b]),
                .wdata(bank_wdata[r][b]),
                .rdata(ram_q[r][b])
            );
        end
    end

    for (p = 0; p < num_rt; p++) begin : g_out
        always_ff @(posedge clk) begin
            for (int k = 0; k < num_bank; k++) begin
                s3_line[p][k] <= ram_q[rgn_d[p]][k];
            end
        end

        // Line held between reads
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                rd_rdy[p] <= 1'b0;
                s4_line[p] <= '0;
            end else begin
                rd_rdy[p] <= vld_d[p];
                if (vld_d[p]) begin
                    s4_line[p] <= s3_line[p];
                end
            end
        end

        // Rotate back by the start bank
        always_comb begin
            for (int k = 0; k < num_bank; k++) begin
                rdata[p][k] = s4_line[p][bank_sel_t'(rot_d[p] + k)];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/burst_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_counter
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   load,
    input  waddr_t                      base,
    input  wire logic [burst_len_w-1:0] len,
    input  wire logic                   issue,
    input  wire logic                   ret,
    output waddr_t                      cur_addr,
    output logic                        issue_last,
    output logic                        ret_last
);

    logic [burst_len_w-1:0] len_q;
    logic [burst_len_w-1:0] issued;
    logic [burst_len_w-1:0] returned;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_addr <= '0;
            len_q <= '0;
            issued <= '0;
            returned <= '0;
        end else if (load) begin
            cur_addr <= base;
            len_q <= len;
            issued <= '0;
            returned <= '0;
        end else begin
            if (issue) begin
                cur_addr <= cur_addr + waddr_t'(num_bank);
                issued <= issued + 1'b1;
            end
            if (ret) begin
                returned <= returned + 1'b1;
            end
        end
    end

    assign issue_last = (issued == len_q - 1'b1);
    assign ret_last = (returned == len_q - 1'b1);

endmodule

`default_nettype wire

// ==== rtl/mc_burst_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module mc_burst_fsm
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic mc_start,
    output logic      mc_busy,
    output logic      mc_valid,
    output logic      mc_done,
    output line_t     mc_rdata,
    input  wire logic rt0_we,
    input  wire logic rt0_re,
    input  waddr_t    rt0_addr,
    input  line_t     rt0_wdata,
    output logic      rt0_rd_rdy,
    output line_t     rt0_rdata,
    output logic      mem0_we,
    output logic      mem0_re,
    output waddr_t    mem0_addr,
    output line_t     mem0_wdata,
    input  wire logic mem0_rd_rdy,
    input  line_t     mem0_rdata,
    output logic      cnt_load,
    output logic      cnt_issue,
    output logic      cnt_ret,
    input  waddr_t    cnt_addr,
    input  wire logic issue_last,
    input  wire logic ret_last
);

    typedef enum logic [1:0] {IDLE, ISSUE, DRAIN} state_t;

    state_t state;
    logic   tag_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:  if (mc_start) state <= ISSUE;
                ISSUE: if (issue_last) state <= DRAIN;
                DRAIN: if (mc_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign mc_busy = (state != IDLE);
    assign cnt_load = mc_start && (state == IDLE);
    assign cnt_issue = (state == ISSUE);

    // Port 0 belongs to the burst outside IDLE
    assign mem0_we = (state == IDLE) ? rt0_we : 1'b0;
    assign mem0_re = (state == IDLE) ? rt0_re : (state == ISSUE);
    assign mem0_addr = (state == ISSUE) ? cnt_addr : rt0_addr;
    assign mem0_wdata = rt0_wdata;

    // Marks which returning reads belong to the burst
    delay_line #(.payload_t(logic), .depth(rd_latency)) u_tag_pipe (
        .clk(clk), .rst_n(rst_n), .d(cnt_issue), .q(tag_d)
    );

    assign mc_valid = mem0_rd_rdy && tag_d;
    assign mc_done = mc_valid && ret_last;
    assign cnt_ret = mc_valid;
    assign mc_rdata = mem0_rdata;
    assign rt0_rd_rdy = mem0_rd_rdy && !tag_d;
    assign rt0_rdata = mem0_rdata;

endmodule

`default_nettype wire

// ==== rtl/rt_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rt_mem_top
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   rt_we [num_rt],
    input  wire logic                   rt_re [num_rt],
    input  waddr_t                      rt_addr [num_rt],
    input  line_t                       rt_wdata [num_rt],
    output logic                        rt_rd_rdy [num_rt],
    output line_t                       rt_rdata [num_rt],
    input  wire logic                   mc_start,
    input  waddr_t                      mc_addr,
    input  wire logic [burst_len_w-1:0] mc_len,
    output logic                        mc_busy,
    output logic                        mc_valid,
    output logic                        mc_done,
    output line_t                       mc_rdata
);

    logic   mem_we [num_rt];
    logic   mem_re [num_rt];
    waddr_t mem_addr [num_rt];
    line_t  mem_wdata [num_rt];
    logic   mem_rd_rdy [num_rt];
    line_t  mem_rdata [num_rt];

    logic   cnt_load;
    logic   cnt_issue;
    logic   cnt_ret;
    waddr_t cnt_addr;
    logic   issue_last;
    logic   ret_last;

    genvar p;

    // Ports 1 and up go straight to the memory
    for (p = 1; p < num_rt; p++) begin : g_direct
        assign mem_we[p] = rt_we[p];
        assign mem_re[p] = rt_re[p];
        assign mem_addr[p] = rt_addr[p];
        assign mem_wdata[p] = rt_wdata[p];
        assign rt_rd_rdy[p] = mem_rd_rdy[p];
        assign rt_rdata[p] = mem_rdata[p];
    end

    mem_main u_mem_main (
        .clk(clk), .rst_n(rst_n),
        .we(mem_we), .re(mem_re), .addr(mem_addr), .wdata(mem_wdata),
        .rd_rdy(mem_rd_rdy), .rdata(mem_rdata)
    );

    mc_burst_fsm u_mc_burst_fsm (
        .clk(clk), .rst_n(rst_n),
        .mc_start(mc_start), .mc_busy(mc_busy), .mc_valid(mc_valid),
        .mc_done(mc_done), .mc_rdata(mc_rdata),
        .rt0_we(rt_we[0]), .rt0_re(rt_re[0]), .rt0_addr(rt_addr[0]),
        .rt0_wdata(rt_wdata[0]), .rt0_rd_rdy(rt_rd_rdy[0]), .rt0_rdata(rt_rdata[0]),
        .mem0_we(mem_we[0]), .mem0_re(mem_re[0]), .mem0_addr(mem_addr[0]),
        .mem0_wdata(mem_wdata[0]), .mem0_rd_rdy(mem_rd_rdy[0]), .mem0_rdata(mem_rdata[0]),
        .cnt_load(cnt_load), .cnt_issue(cnt_issue), .cnt_ret(cnt_ret),
        .cnt_addr(cnt_addr), .issue_last(issue_last), .ret_last(ret_last)
    );

    burst_counter u_burst_counter (
        .clk(clk), .rst_n(rst_n),
        .load(cnt_load), .base(mc_addr), .len(mc_len),
        .issue(cnt_issue), .ret(cnt_ret),
        .cur_addr(cnt_addr), .issue_last(issue_last), .ret_last(ret_last)
    );

endmodule

`default_nettype wire

// ==== tb/rt_mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rt_mem_checker
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [2:0]             test_id,
    input  wire logic                   rt_we [num_rt],
    input  wire logic                   rt_re [num_rt],
    input  waddr_t                      rt_addr [num_rt],
    input  line_t                       rt_wdata [num_rt],
    input  wire logic                   rt_rd_rdy [num_rt],
    input  line_t                       rt_rdata [num_rt],
    input  wire logic                   mc_start,
    input  waddr_t                      mc_addr,
    input  wire logic [burst_len_w-1:0] mc_len,
    input  wire logic                   mc_busy,
    input  wire logic                   mc_valid,
    input  wire logic                   mc_done,
    input  line_t                       mc_rdata,
    output int                          mismatch_errors,
    output int                          protocol_errors
);

    // Expected results are filed by the cycle they are due in
    localparam int ring_size = 8;

    word_t model [2**addr_w];

    logic       exp_vld [num_rt][ring_size];
    line_t      exp_line [num_rt][ring_size];
    logic [2:0] exp_test [num_rt][ring_size];
    logic       mc_vld [ring_size];
    line_t      mc_line [ring_size];
    logic       mc_last [ring_size];
    logic [2:0] mc_test [ring_size];
    logic       seen_rdy [num_rt];
    logic       seen_mc;

    logic        busy_exp;
    int          burst_left;
    waddr_t      burst_addr;
    int unsigned busy_end;
    int unsigned cycle;

    logic   eff_we [num_rt];
    logic   eff_re [num_rt];
    waddr_t eff_addr [num_rt];
    logic   eff_burst;
    logic   owned [num_region];
    int     owner [num_region];

    initial begin
        mismatch_errors = 0;
        protocol_errors = 0;
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0: return "reset";
            3'd1: return "aligned_fill";
            3'd2: return "unaligned";
            3'd3: return "back_to_back";
            3'd4: return "conflict";
            3'd5: return "burst";
            default: return "unknown";
        endcase
    endfunction

    // Owner's line read out from the reader's start bank
    function automatic line_t predict_read(input waddr_t own, input waddr_t rd);
        line_t     l;
        bank_sel_t b;
        row_t      row;
        for (int k = 0; k < num_bank; k++) begin
            b = bank_sel_t'(rd[1:0] + k);
            row = own[7:2] + row_t'(b < own[1:0]);
            l[k] = model[{own[9:8], row, b}];
        end
        return l;
    endfunction

    // Line wraps inside its region
    task automatic apply_write(input waddr_t a, input line_t d);
        for (int k = 0; k < num_bank; k++) begin
            model[{a[9:8], 8'(a[7:0] + 8'(k))}] = d[k];
        end
    endtask

    task automatic clear_state();
        for (int i = 0; i < ring_size; i++) begin
            for (int p = 0; p < num_rt; p++) begin
                exp_vld[p][i] = 1'b0;
            end
            mc_vld[i] = 1'b0;
        end
        for (int p = 0; p < num_rt; p++) begin
            seen_rdy[p] = 1'b0;
        end
        seen_mc = 1'b0;
        busy_exp = 1'b0;
        burst_left = 0;
        cycle = 0;
    endtask

    task automatic check_returns();
        int slot;
        slot = cycle % ring_size;
        for (int p = 0; p < num_rt; p++) begin
            if (exp_vld[p][slot]) begin
                if (rt_rd_rdy[p] !== 1'b1) begin
                    $display("Error: port %0d read result missing in test %s",
                             p, test_name(exp_test[p][slot]));
                    protocol_errors++;
                end else if (rt_rdata[p] !== exp_line[p][slot]) begin
                    $display("Fail %s: port %0d expected %h actual %h",
                             test_name(exp_test[p][slot]), p, exp_line[p][slot], rt_rdata[p]);
                    mismatch_errors++;
                end
                exp_vld[p][slot] = 1'b0;
            end else if (rt_rd_rdy[p] !== 1'b0) begin
                $display("Error: port %0d returned a read that was never issued in test %s",
                         p, test_name(test_id));
                protocol_errors++;
            end else if (!seen_rdy[p] && rt_rdata[p] !== '0) begin
                $display("Fail reset: port %0d rdata expected %h actual %h",
                         p, line_t'(0), rt_rdata[p]);
                mismatch_errors++;
            end
            if (rt_rd_rdy[p] === 1'b1) begin
                seen_rdy[p] = 1'b1;
            end
        end

        if (mc_vld[slot]) begin
            if (mc_valid !== 1'b1) begin
                $display("Error: burst line missing in test %s", test_name(mc_test[slot]));
                protocol_errors++;
            end else begin
                if (mc_rdata !== mc_line[slot]) begin
                    $display("Fail %s: mc_rdata expected %h actual %h",
                             test_name(mc_test[slot]), mc_line[slot], mc_rdata);
                    mismatch_errors++;
                end
                if (mc_done !== mc_last[slot]) begin
                    $display("Fail %s: mc_done expected %b actual %b",
                             test_name(mc_test[slot]), mc_last[slot], mc_done);
                    mismatch_errors++;
                end
            end
            mc_vld[slot] = 1'b0;
        end else if (mc_valid !== 1'b0 || mc_done !== 1'b0) begin
            $display("Error: mc_valid or mc_done pulsed with no burst line due in test %s",
                     test_name(test_id));
            protocol_errors++;
        end else if (!seen_rdy[0] && !seen_mc && mc_rdata !== '0) begin
            $display("Fail reset: mc_rdata expected %h actual %h", line_t'(0), mc_rdata);
            mismatch_errors++;
        end
        if (mc_valid === 1'b1) begin
            seen_mc = 1'b1;
        end

        if (mc_busy !== busy_exp) begin
            $display("Fail %s: mc_busy expected %b actual %b",
                     test_name(test_id), busy_exp, mc_busy);
            mismatch_errors++;
        end
    endtask

    task automatic issue_requests();
        int      slot;
        int      own;
        line_t   line;
        region_t rgn;
        slot = (cycle + rd_latency) % ring_size;
        for (int p = 0; p < num_rt; p++) begin
            eff_we[p] = rt_we[p];
            eff_re[p] = rt_re[p];
            eff_addr[p] = rt_addr[p];
        end
        eff_burst = 1'b0;

        // RT port 0 is shut out while a burst runs
        if (busy_exp) begin
            eff_we[0] = 1'b0;
            eff_re[0] = 1'b0;
            if (burst_left > 0) begin
                eff_re[0] = 1'b1;
                eff_addr[0] = burst_addr;
                eff_burst = 1'b1;
                burst_addr = burst_addr + waddr_t'(num_bank);
                burst_left--;
            end
        end

        for (int r = 0; r < num_region; r++) begin
            owned[r] = 1'b0;
            owner[r] = 0;
        end
        for (int p = 0; p < num_rt; p++) begin
            rgn = eff_addr[p][9:8];
            if ((eff_we[p] || eff_re[p]) && !owned[rgn]) begin
                owned[rgn] = 1'b1;
                owner[rgn] = p;
            end
        end

        // Reads see memory before this cycle's writes
        for (int p = 0; p < num_rt; p++) begin
            if (eff_re[p]) begin
                rgn = eff_addr[p][9:8];
                own = owner[rgn];
                line = predict_read(eff_addr[own], eff_addr[p]);
                if (p == 0 && eff_burst) begin
                    mc_vld[slot] = 1'b1;
                    mc_line[slot] = line;
                    mc_last[slot] = (burst_left == 0);
                    mc_test[slot] = test_id;
                end else begin
                    exp_vld[p][slot] = 1'b1;
                    exp_line[p][slot] = line;
                    exp_test[p][slot] = test_id;
                end
            end
        end

        for (int r = 0; r < num_region; r++) begin
            if (owned[r] && eff_we[owner[r]]) begin
                apply_write(eff_addr[owner[r]], rt_wdata[owner[r]]);
            end
        end
    endtask

    task automatic update_busy();
        if (busy_exp) begin
            if (cycle == busy_end) begin
                busy_exp = 1'b0;
            end
        end else if (mc_start === 1'b1) begin
            busy_exp = 1'b1;
            burst_addr = mc_addr;
            burst_left = int'(mc_len);
            busy_end = cycle + mc_len + rd_latency;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            clear_state();
        end else begin
            check_returns();
            issue_requests();
            update_busy();
            cycle++;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_rt_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rt_mem
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
();

    localparam int fill_lines = 64;
    localparam int unaligned_cycles = 48;
    localparam int b2b_cycles = 40;
    localparam int conflict_cycles = 64;
    localparam int num_bursts = 8;
    localparam int burst_max_cycles = 2 + 16 + rd_latency;
    localparam int drain_cycles = rd_latency + 3;
    localparam int stim_cycles = 2 + 4 + 2 * fill_lines + unaligned_cycles + b2b_cycles
                                 + conflict_cycles + num_bursts * burst_max_cycles
                                 + drain_cycles;
    localparam int timeout_cycles = stim_cycles + 64;

    logic clk;
    logic rst_n;

    logic   rt_we [num_rt];
    logic   rt_re [num_rt];
    waddr_t rt_addr [num_rt];
    line_t  rt_wdata [num_rt];
    logic   rt_rd_rdy [num_rt];
    line_t  rt_rdata [num_rt];

    logic                   mc_start;
    waddr_t                 mc_addr;
    logic [burst_len_w-1:0] mc_len;
    logic                   mc_busy;
    logic                   mc_valid;
    logic                   mc_done;
    line_t                  mc_rdata;

    logic [2:0]  test_id;
    logic [31:0] rng_state;
    int unsigned cycle_cnt = 0;
    int          mismatch_errors;
    int          protocol_errors;

    rt_mem_top u_rt_mem_top (
        .clk(clk), .rst_n(rst_n),
        .rt_we(rt_we), .rt_re(rt_re), .rt_addr(rt_addr), .rt_wdata(rt_wdata),
        .rt_rd_rdy(rt_rd_rdy), .rt_rdata(rt_rdata),
        .mc_start(mc_start), .mc_addr(mc_addr), .mc_len(mc_len),
        .mc_busy(mc_busy), .mc_valid(mc_valid), .mc_done(mc_done), .mc_rdata(mc_rdata)
    );

    rt_mem_checker u_rt_mem_checker (
        .clk(clk), .rst_n(rst_n), .test_id(test_id),
        .rt_we(rt_we), .rt_re(rt_re), .rt_addr(rt_addr), .rt_wdata(rt_wdata),
        .rt_rd_rdy(rt_rd_rdy), .rt_rdata(rt_rdata),
        .mc_start(mc_start), .mc_addr(mc_addr), .mc_len(mc_len),
        .mc_busy(mc_busy), .mc_valid(mc_valid), .mc_done(mc_done), .mc_rdata(mc_rdata),
        .mismatch_errors(mismatch_errors), .protocol_errors(protocol_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int k = 0; k < num_bank; k++) begin
            l[k] = rand_word();
        end
        return l;
    endfunction

    task automatic clear_strobes();
        for (int p = 0; p < num_rt; p++) begin
            rt_we[p] = 1'b0;
            rt_re[p] = 1'b0;
        end
        mc_start = 1'b0;
    endtask

    // Quarter writes, half reads, quarter idle
    task automatic drive_op(input int p, input waddr_t a);
        logic [31:0] r;
        r = rand_word();
        rt_addr[p] = a;
        rt_wdata[p] = rand_line();
        rt_we[p] = (r[1:0] == 2'd1);
        rt_re[p] = (r[1:0] >= 2'd2);
    endtask

    task automatic drive_traffic();
        for (int p = 0; p < num_rt; p++) begin
            drive_op(p, waddr_t'(rand_word()));
        end
    endtask

    task automatic run_aligned_fill();
        test_id = 3'd1;
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < fill_lines; i++) begin
                @(negedge clk);
                clear_strobes();
                for (int p = 0; p < num_rt; p++) begin
                    rt_addr[p] = {region_t'(p), row_t'(i), bank_sel_t'(0)};
                    rt_wdata[p] = rand_line();
                    rt_we[p] = (pass == 0);
                    rt_re[p] = (pass == 1);
                end
            end
        end
    endtask

    task automatic run_unaligned();
        logic [7:0] off;
        test_id = 3'd2;
        for (int c = 0; c < unaligned_cycles; c++) begin
            @(negedge clk);
            clear_strobes();
            for (int p = 0; p < num_rt; p++) begin
                off = 8'(rand_word());
                // Start in the last row of the region now and then
                if ((c % num_rt) == p) begin
                    off[7:2] = 6'h3f;
                end
                drive_op(p, {region_t'(p), off});
            end
        end
    endtask

    task automatic run_back_to_back();
        test_id = 3'd3;
        for (int c = 0; c < b2b_cycles; c++) begin
            @(negedge clk);
            clear_strobes();
            for (int p = 0; p < num_rt; p++) begin
                rt_addr[p] = waddr_t'(rand_word());
                rt_re[p] = 1'b1;
            end
        end
    endtask

    task automatic run_conflicts();
        test_id = 3'd4;
        for (int c = 0; c < conflict_cycles; c++) begin
            @(negedge clk);
            clear_strobes();
            for (int p = 0; p < num_rt; p++) begin
                // Only regions 0 and 1 so ports collide often
                drive_op(p, waddr_t'(rand_word() & 32'h1ff));
            end
        end
    endtask

    task automatic run_bursts();
        logic        done_seen;
        logic [31:0] r;
        test_id = 3'd5;
        for (int n = 0; n < num_bursts; n++) begin
            @(negedge clk);
            clear_strobes();
            r = rand_word();
            mc_start = 1'b1;
            mc_addr = waddr_t'(r);
            mc_len = burst_len_w'(r[31:28]) + 1'b1;
            drive_traffic();
            done_seen = 1'b0;
            while (!done_seen) begin
                @(negedge clk);
                done_seen = mc_done;
                clear_strobes();
                r = rand_word();
                // Starts while busy must be ignored
                mc_start = (r[2:0] == 3'd0);
                drive_traffic();
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Error: run did not finish within %0d cycles", timeout_cycles);
            $display("Errors: mismatch %0d, protocol %0d", mismatch_errors, protocol_errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        rng_state = 32'hd8a8b86f;
        test_id = 3'd0;
        rst_n = 1'b0;
        clear_strobes();
        for (int p = 0; p < num_rt; p++) begin
            rt_addr[p] = '0;
            rt_wdata[p] = '0;
        end
        mc_addr = '0;
        mc_len = '0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        run_aligned_fill();
        run_unaligned();
        run_back_to_back();
        run_conflicts();
        run_bursts();

        repeat (drain_cycles) begin
            @(negedge clk);
            clear_strobes();
        end

        $display("Errors: mismatch %0d, protocol %0d", mismatch_errors, protocol_errors);
        if (mismatch_errors == 0 && protocol_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/mem_cfg_pkg.sv
rtl/mem_types_pkg.sv
rtl/delay_line.sv
rtl/bank_ram.sv
rtl/mem_main.sv
rtl/burst_counter.sv
rtl/mc_burst_fsm.sv
rtl/rt_mem_top.sv
tb/rt_mem_checker.sv
tb/tb_rt_mem.sv

// ==== Bender.yml ====
package:
  name: rt_mem

sources:
  - rtl/mem_cfg_pkg.sv
  - rtl/mem_types_pkg.sv
  - rtl/delay_line.sv
  - rtl/bank_ram.sv
  - rtl/mem_main.sv
  - rtl/burst_counter.sv
  - rtl/mc_burst_fsm.sv
  - rtl/rt_mem_top.sv
  - target: simulation
    files:
      - tb/rt_mem_checker.sv
      - tb/tb_rt_mem.sv
